// File: hdl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    localparam int xlen = 64;

    typedef logic [xlen-1:0] xword_t;  // data value or address
    typedef logic [4:0]      reg_idx_t;  // x0 reads as zero
    typedef logic [2:0]      func3_t;  // branch cond or access size

    typedef enum logic [4:0] {
        alu_add    = 5'd0,
        alu_sub    = 5'd1,
        alu_sll    = 5'd2,
        alu_slt    = 5'd3,
        alu_sltu   = 5'd4,
        alu_xor    = 5'd5,
        alu_srl    = 5'd6,
        alu_sra    = 5'd7,
        alu_or     = 5'd8,
        alu_and    = 5'd9,
        alu_addw   = 5'd10,
        alu_subw   = 5'd11,
        alu_sllw   = 5'd12,
        alu_srlw   = 5'd13,
        alu_sraw   = 5'd14,
        alu_pass_b = 5'd15  // lui
    } alu_op_e;

    typedef enum logic [1:0] {a_sel_reg, a_sel_pc, a_sel_zero} alu_a_sel_e;

    typedef enum logic [1:0] {b_sel_reg, b_sel_imm, b_sel_zero, b_sel_four} alu_b_sel_e;

    // ms has the younger value, so it wins over ws
    typedef enum logic [1:0] {
        fwd_none    = 2'b00,
        fwd_from_ws = 2'b01,
        fwd_from_ms = 2'b10
    } fwd_sel_e;

    typedef enum logic [1:0] {br_none, br_branch, br_jal, br_jalr} br_kind_e;

    localparam func3_t f3_beq  = 3'b000;
    localparam func3_t f3_bne  = 3'b001;
    localparam func3_t f3_blt  = 3'b100;
    localparam func3_t f3_bge  = 3'b101;
    localparam func3_t f3_bltu = 3'b110;
    localparam func3_t f3_bgeu = 3'b111;

endpackage

`default_nettype wire

// File: hdl/pipe_bus_pkg.sv
`default_nettype none

package pipe_bus_pkg;

    import rv_isa_pkg::*;

    // decoded instruction entering execute
    typedef struct packed {
        xword_t     pc;
        xword_t     src1;  // register file values, not forwarded
        xword_t     src2;
        xword_t     imm;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   rd;
        logic       reg_wen;
        logic       mem_wen;
        logic       mem_ren;
        func3_t     func3;
        alu_op_e    alu_op;
        alu_a_sel_e a_sel;
        alu_b_sel_e b_sel;
        br_kind_e   br_kind;
    } dec_bundle_t;

    // execute result, carried through memory and write-back
    typedef struct packed {
        xword_t   pc;
        xword_t   result;  // alu result, load address for loads
        xword_t   store_data;
        reg_idx_t rd;
        logic     reg_wen;
        logic     mem_wen;
        logic     mem_ren;
        func3_t   func3;
    } ms_bundle_t;

    typedef struct packed {
        xword_t target;
        logic   taken;
        xword_t link;  // pc + 4
    } redirect_t;

    // one stage as seen by the forwarding logic
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        logic     reg_wen;
        xword_t   result;
    } fwd_tap_t;

endpackage

`default_nettype wire

// File: hdl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  rv_isa_pkg::xword_t  a,
    input  rv_isa_pkg::xword_t  b,
    input  rv_isa_pkg::alu_op_e op,
    output rv_isa_pkg::xword_t  result
);

    import rv_isa_pkg::*;

    logic [5:0]  shamt;
    logic [4:0]  shamt_w;
    logic [31:0] word_res;  // low half for the *w forms

    assign shamt   = b[5:0];
    assign shamt_w = b[4:0];

    always_comb begin
        case (op)
            alu_addw: word_res = a[31:0] + b[31:0];
            alu_subw: word_res = a[31:0] - b[31:0];
            alu_sllw: word_res = a[31:0] << shamt_w;
            alu_srlw: word_res = a[31:0] >> shamt_w;
            alu_sraw: word_res = $signed(a[31:0]) >>> shamt_w;
            default:  word_res = 32'd0;
        endcase
    end

    always_comb begin
        case (op)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_sll:    result = a << shamt;
            alu_slt:    result = {63'd0, $signed(a) < $signed(b)};
            alu_sltu:   result = {63'd0, a < b};
            alu_xor:    result = a ^ b;
            alu_srl:    result = a >> shamt;
            alu_sra:    result = $signed(a) >>> shamt;
            alu_or:     result = a | b;
            alu_and:    result = a & b;
            alu_addw, alu_subw, alu_sllw, alu_srlw, alu_sraw:
                result = {{32{word_res[31]}}, word_res};  // sign extend
            alu_pass_b: result = b;
            default:    result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
    input  rv_isa_pkg::br_kind_e   kind,
    input  rv_isa_pkg::func3_t     cond,
    input  rv_isa_pkg::xword_t     rs1_val,
    input  rv_isa_pkg::xword_t     rs2_val,
    input  rv_isa_pkg::xword_t     pc,
    input  rv_isa_pkg::xword_t     imm,
    output pipe_bus_pkg::redirect_t redirect
);

    import rv_isa_pkg::*;

    logic   cond_met;
    xword_t pc_target;
    xword_t reg_target;

    // compare the forwarded operands
    always_comb begin
        case (cond)
            f3_beq:  cond_met = (rs1_val == rs2_val);
            f3_bne:  cond_met = (rs1_val != rs2_val);
            f3_blt:  cond_met = ($signed(rs1_val) < $signed(rs2_val));
            f3_bge:  cond_met = ($signed(rs1_val) >= $signed(rs2_val));
            f3_bltu: cond_met = (rs1_val < rs2_val);
            f3_bgeu: cond_met = (rs1_val >= rs2_val);
            default: cond_met = 1'b0;  // reserved encodings
        endcase
    end

    assign pc_target  = pc + imm;
    assign reg_target = (rs1_val + imm) & ~64'd1;  // jalr drops bit 0

    always_comb begin
        redirect.link = pc + 64'd4;
        case (kind)
            br_branch: begin
                redirect.taken  = cond_met;
                redirect.target = pc_target;
            end
            br_jal: begin
                redirect.taken  = 1'b1;
                redirect.target = pc_target;
            end
            br_jalr: begin
                redirect.taken  = 1'b1;
                redirect.target = reg_target;
            end
            default: begin
                redirect.taken  = 1'b0;
                redirect.target = pc_target;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/forward_unit.sv
`timescale 1ns/1ps
`default_nettype none

module forward_unit (
    input  rv_isa_pkg::reg_idx_t  rs1,
    input  rv_isa_pkg::reg_idx_t  rs2,
    input  pipe_bus_pkg::fwd_tap_t ms_tap,
    input  pipe_bus_pkg::fwd_tap_t ws_tap,
    output rv_isa_pkg::fwd_sel_e  fwd_a,
    output rv_isa_pkg::fwd_sel_e  fwd_b
);

    import rv_isa_pkg::*;
    import pipe_bus_pkg::*;

    // a live writer of a nonzero register that matches the source
    function automatic logic tap_hit(fwd_tap_t tap, reg_idx_t rs);
        return tap.valid && tap.reg_wen && (tap.rd != 5'd0) && (tap.rd == rs);
    endfunction

    function automatic fwd_sel_e pick(reg_idx_t rs, fwd_tap_t ms, fwd_tap_t ws);
        fwd_sel_e sel;
        if (tap_hit(ms, rs)) begin
            sel = fwd_from_ms;  // youngest writer
        end else if (tap_hit(ws, rs)) begin
            sel = fwd_from_ws;
        end else begin
            sel = fwd_none;
        end
        return sel;
    endfunction

    assign fwd_a = pick(rs1, ms_tap, ws_tap);
    assign fwd_b = pick(rs2, ms_tap, ws_tap);

endmodule

`default_nettype wire

// File: hdl/exe_stage.sv
`timescale 1ns/1ps
`default_nettype none

module exe_stage (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      in_valid,
    input  pipe_bus_pkg::dec_bundle_t in_bus,
    output logic                     es_allowin,
    input  wire                      ms_allowin,
    output logic                     es_to_ms_valid,
    output pipe_bus_pkg::ms_bundle_t  es_to_ms_bus,
    output rv_isa_pkg::reg_idx_t     es_rs1,
    output rv_isa_pkg::reg_idx_t     es_rs2,
    input  rv_isa_pkg::fwd_sel_e     fwd_a,
    input  rv_isa_pkg::fwd_sel_e     fwd_b,
    input  rv_isa_pkg::xword_t       ms_result,
    input  rv_isa_pkg::xword_t       ws_result,
    output logic                     redirect_valid,
    output pipe_bus_pkg::redirect_t   redirect
);

    import rv_isa_pkg::*;
    import pipe_bus_pkg::*;

    logic        es_valid;
    dec_bundle_t es_bus;
    xword_t      fwd_src1;
    xword_t      fwd_src2;
    xword_t      alu_a;
    xword_t      alu_b;
    xword_t      alu_result;

    assign es_allowin     = !es_valid || ms_allowin;  // never waits on itself
    assign es_to_ms_valid = es_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && es_allowin) begin
            es_bus <= in_bus;
        end
    end

    assign es_rs1 = es_bus.rs1;
    assign es_rs2 = es_bus.rs2;

    // forwarded register values first, then the operand selects
    always_comb begin
        case (fwd_a)
            fwd_from_ms: fwd_src1 = ms_result;
            fwd_from_ws: fwd_src1 = ws_result;
            default:     fwd_src1 = es_bus.src1;
        endcase
        case (fwd_b)
            fwd_from_ms: fwd_src2 = ms_result;
            fwd_from_ws: fwd_src2 = ws_result;
            default:     fwd_src2 = es_bus.src2;
        endcase
    end

    always_comb begin
        case (es_bus.a_sel)
            a_sel_reg: alu_a = fwd_src1;
            a_sel_pc:  alu_a = es_bus.pc;
            default:   alu_a = '0;
        endcase
        case (es_bus.b_sel)
            b_sel_reg:  alu_b = fwd_src2;
            b_sel_imm:  alu_b = es_bus.imm;
            b_sel_four: alu_b = 64'd4;  // link value with pc on a
            default:    alu_b = '0;
        endcase
    end

    alu i_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (es_bus.alu_op),
        .result (alu_result)
    );

    branch_unit i_branch_unit (
        .kind     (es_bus.br_kind),
        .cond     (es_bus.func3),
        .rs1_val  (fwd_src1),
        .rs2_val  (fwd_src2),
        .pc       (es_bus.pc),
        .imm      (es_bus.imm),
        .redirect (redirect)
    );

    // one pulse per control instruction, on its move into memory
    assign redirect_valid = es_valid && ms_allowin && (es_bus.br_kind != br_none);

    assign es_to_ms_bus = '{
        pc:         es_bus.pc,
        result:     alu_result,
        store_data: fwd_src2,
        rd:         es_bus.rd,
        reg_wen:    es_bus.reg_wen,
        mem_wen:    es_bus.mem_wen,
        mem_ren:    es_bus.mem_ren,
        func3:      es_bus.func3
    };

endmodule

`default_nettype wire

// File: hdl/retire_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module retire_pipe (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     es_to_ms_valid,
    input  pipe_bus_pkg::ms_bundle_t es_to_ms_bus,
    output logic                    ms_allowin,
    output pipe_bus_pkg::fwd_tap_t   ms_tap,
    output pipe_bus_pkg::fwd_tap_t   ws_tap,
    input  wire                     retire_ready,
    output logic                    retire_valid,
    output pipe_bus_pkg::ms_bundle_t retire
);

    import pipe_bus_pkg::*;

    logic       ms_valid;
    ms_bundle_t ms_bus;
    logic       ws_valid;
    ms_bundle_t ws_bus;
    logic       ws_allowin;

    assign ws_allowin = !ws_valid || retire_ready;
    assign ms_allowin = !ms_valid || ws_allowin;

    // memory stage, no data memory behind it
    always_ff @(posedge clk) begin
        if (rst) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= es_to_ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es_to_ms_valid && ms_allowin) begin
            ms_bus <= es_to_ms_bus;
        end
    end

    // write-back stage doubles as the retire slot
    always_ff @(posedge clk) begin
        if (rst) begin
            ws_valid <= 1'b0;
        end else if (ws_allowin) begin
            ws_valid <= ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms_valid && ws_allowin) begin
            ws_bus <= ms_bus;
        end
    end

    assign ms_tap = '{valid: ms_valid, rd: ms_bus.rd, reg_wen: ms_bus.reg_wen,
                      result: ms_bus.result};
    assign ws_tap = '{valid: ws_valid, rd: ws_bus.rd, reg_wen: ws_bus.reg_wen,
                      result: ws_bus.result};

    assign retire_valid = ws_valid;
    assign retire       = ws_bus;

endmodule

`default_nettype wire

// File: hdl/exec_cluster.sv
`timescale 1ns/1ps
`default_nettype none

module exec_cluster (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      in_valid,
    input  pipe_bus_pkg::dec_bundle_t in_bus,
    output logic                     in_allowin,
    input  wire                      retire_ready,
    output logic                     retire_valid,
    output pipe_bus_pkg::ms_bundle_t  retire,
    output logic                     redirect_valid,
    output pipe_bus_pkg::redirect_t   redirect
);

    import rv_isa_pkg::*;
    import pipe_bus_pkg::*;

    logic       es_to_ms_valid;
    ms_bundle_t es_to_ms_bus;
    logic       ms_allowin;
    fwd_tap_t   ms_tap;
    fwd_tap_t   ws_tap;
    reg_idx_t   es_rs1;
    reg_idx_t   es_rs2;
    fwd_sel_e   fwd_a;
    fwd_sel_e   fwd_b;

    exe_stage i_exe_stage (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .in_bus         (in_bus),
        .es_allowin     (in_allowin),
        .ms_allowin     (ms_allowin),
        .es_to_ms_valid (es_to_ms_valid),
        .es_to_ms_bus   (es_to_ms_bus),
        .es_rs1         (es_rs1),
        .es_rs2         (es_rs2),
        .fwd_a          (fwd_a),
        .fwd_b          (fwd_b),
        .ms_result      (ms_tap.result),  // forwarded values straight off the taps
        .ws_result      (ws_tap.result),
        .redirect_valid (redirect_valid),
        .redirect       (redirect)
    );

    forward_unit i_forward_unit (
        .rs1    (es_rs1),
        .rs2    (es_rs2),
        .ms_tap (ms_tap),
        .ws_tap (ws_tap),
        .fwd_a  (fwd_a),
        .fwd_b  (fwd_b)
    );

    retire_pipe i_retire_pipe (
        .clk            (clk),
        .rst            (rst),
        .es_to_ms_valid (es_to_ms_valid),
        .es_to_ms_bus   (es_to_ms_bus),
        .ms_allowin     (ms_allowin),
        .ms_tap         (ms_tap),
        .ws_tap         (ws_tap),
        .retire_ready   (retire_ready),
        .retire_valid   (retire_valid),
        .retire         (retire)
    );

endmodule

`default_nettype wire

// File: include/exec_ref_model.svh
`ifndef EXEC_REF_MODEL_SVH
`define EXEC_REF_MODEL_SVH

// sequential RV64I semantics, one instruction at a time
function automatic xword_t alu_model(xword_t a, xword_t b, alu_op_e op);
    logic [31:0] w;
    xword_t      r;
    w = 32'd0;
    r = 64'd0;
    case (op)
        alu_add:    r = a + b;
        alu_sub:    r = a + ~b + 64'd1;  // two's complement
        alu_sll:    r = a << b[5:0];
        alu_slt:    r = {63'd0, $signed(a) < $signed(b)};
        alu_sltu:   r = {63'd0, a < b};
        alu_xor:    r = a ^ b;
        alu_srl:    r = a >> b[5:0];
        alu_sra:    r = $signed(a) >>> b[5:0];
        alu_or:     r = a | b;
        alu_and:    r = a & b;
        alu_addw:   w = a[31:0] + b[31:0];
        alu_subw:   w = a[31:0] - b[31:0];
        alu_sllw:   w = a[31:0] << b[4:0];
        alu_srlw:   w = a[31:0] >> b[4:0];
        alu_sraw:   w = $signed(a[31:0]) >>> b[4:0];
        alu_pass_b: r = b;
        default:    r = 64'd0;
    endcase
    if (op inside {alu_addw, alu_subw, alu_sllw, alu_srlw, alu_sraw}) begin
        r = {{32{w[31]}}, w};  // word result widened by sign
    end
    return r;
endfunction

function automatic logic branch_taken(func3_t f3, xword_t a, xword_t b);
    logic t;
    case (f3)
        f3_beq:  t = (a == b);
        f3_bne:  t = (a != b);
        f3_blt:  t = ($signed(a) < $signed(b));
        f3_bge:  t = !($signed(a) < $signed(b));
        f3_bltu: t = (a < b);
        f3_bgeu: t = !(a < b);
        default: t = 1'b0;
    endcase
    return t;
endfunction

// a and b are the architectural rs1 and rs2 values
function automatic redirect_t redirect_model(dec_bundle_t d, xword_t a, xword_t b);
    redirect_t r;
    xword_t    jump;
    jump     = a + d.imm;
    r.link   = d.pc + 64'd4;
    r.taken  = (d.br_kind == br_branch) ? branch_taken(d.func3, a, b) : 1'b1;
    r.target = (d.br_kind == br_jalr) ? {jump[63:1], 1'b0} : d.pc + d.imm;
    return r;
endfunction

`endif

// File: testbench/exec_cluster_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exec_cluster_tb;

    import rv_isa_pkg::*;
    import pipe_bus_pkg::*;

    `include "exec_ref_model.svh"

    localparam int n_instr    = 400;
    localparam int clk_period = 4;
    localparam int rst_cycles = 8;
    localparam int n_regs     = 5;  // x0..x4 only for dense dependencies

    logic        clk;
    logic        rst;
    logic        in_valid;
    dec_bundle_t in_bus;
    logic        in_allowin;
    logic        retire_ready;
    logic        retire_valid;
    ms_bundle_t  retire;
    logic        redirect_valid;
    redirect_t   redirect;

    integer      seed;
    dec_bundle_t prog [n_instr];
    xword_t      exp_result [n_instr];
    xword_t      exp_store [n_instr];
    int          dep_dist [n_instr];  // 0 when no writer within 3
    int          acc_cycle [n_instr];
    redirect_t   exp_redirect [$];
    xword_t      shadow [32];
    xword_t      golden [32];
    int          cov_hits [4][2];  // indexed by distance and bubble
    int          drv_idx;
    int          ret_cnt;
    int          cycle;
    logic        took;
    logic        held;
    xword_t      held_pc;

    exec_cluster i_exec_cluster (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .in_bus         (in_bus),
        .in_allowin     (in_allowin),
        .retire_ready   (retire_ready),
        .retire_valid   (retire_valid),
        .retire         (retire),
        .redirect_valid (redirect_valid),
        .redirect       (redirect)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #((n_instr * 20 + rst_cycles) * clk_period);
        fail_run("Timeout: the program did not retire in time");
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic expect_equal(input string name, input xword_t got, input xword_t exp);
        assert (got === exp)
        else fail_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    function automatic int unsigned rand_below(int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic dec_bundle_t make_instr(xword_t pc);
        dec_bundle_t d;
        logic [11:0] imm12;
        int unsigned kind;
        imm12     = 12'(rand_below(4096));
        kind      = rand_below(10);
        d         = '0;
        d.pc      = pc;
        d.imm     = {{52{imm12[11]}}, imm12};
        d.rs1     = reg_idx_t'(rand_below(n_regs));
        d.rs2     = reg_idx_t'(rand_below(n_regs));
        d.rd      = reg_idx_t'(rand_below(n_regs));
        d.reg_wen = 1'b1;
        d.func3   = func3_t'(rand_below(8));
        d.alu_op  = alu_op_e'(5'(rand_below(16)));
        d.a_sel   = a_sel_reg;
        d.b_sel   = b_sel_reg;
        d.br_kind = br_none;
        case (kind)
            2: d.b_sel = b_sel_imm;
            3: begin  // lui
                d.a_sel  = a_sel_zero;
                d.b_sel  = b_sel_imm;
                d.imm    = d.imm << 12;
                d.alu_op = alu_pass_b;
            end
            4: begin  // auipc
                d.a_sel  = a_sel_pc;
                d.b_sel  = b_sel_imm;
                d.alu_op = alu_add;
            end
            5: d.b_sel = b_sel_zero;
            6: begin
                d.br_kind = br_branch;
                d.rd      = 5'd0;
                d.reg_wen = 1'b0;
                if (d.func3[2:1] == 2'b01) begin
                    d.func3[2] = 1'b1;  // skip reserved conditions
                end
            end
            7, 8: begin  // link written as pc + 4
                d.br_kind = (kind == 7) ? br_jal : br_jalr;
                d.a_sel   = a_sel_pc;
                d.b_sel   = b_sel_four;
                d.alu_op  = alu_add;
            end
            9: begin
                d.b_sel  = b_sel_imm;
                d.alu_op = alu_add;
                d.func3  = func3_t'(rand_below(4));
                if (rand_below(2) == 0) begin
                    d.mem_wen = 1'b1;
                    d.reg_wen = 1'b0;
                    d.rd      = 5'd0;
                end else begin
                    d.mem_ren = 1'b1;  // address retires as result
                end
            end
            default: ;
        endcase
        return d;
    endfunction

    // register file read with write-first bypass of the retiring bundle
    function automatic xword_t read_src(reg_idx_t r);
        if (r == 5'd0) begin
            return 64'd0;
        end
        if (retire_valid && retire_ready && retire.reg_wen && retire.rd == r) begin
            return retire.result;
        end
        return shadow[r];
    endfunction

    task automatic retire_compare();
        dec_bundle_t d;
        assert (ret_cnt < drv_idx) else fail_run("More instructions retired than were accepted");
        d = prog[ret_cnt];
        expect_equal("retire.pc", retire.pc, d.pc);
        expect_equal("retire.rd", xword_t'(retire.rd), xword_t'(d.rd));
        expect_equal("retire.reg_wen", xword_t'(retire.reg_wen), xword_t'(d.reg_wen));
        expect_equal("retire.result", retire.result, exp_result[ret_cnt]);
        expect_equal("retire.mem_wen", xword_t'(retire.mem_wen), xword_t'(d.mem_wen));
        expect_equal("retire.mem_ren", xword_t'(retire.mem_ren), xword_t'(d.mem_ren));
        expect_equal("retire.func3", xword_t'(retire.func3), xword_t'(d.func3));
        if (d.mem_wen) begin
            expect_equal("retire.store_data", retire.store_data, exp_store[ret_cnt]);
        end
        if (retire.reg_wen && retire.rd != 5'd0) begin
            shadow[retire.rd] = retire.result;
        end
        ret_cnt++;
    endtask

    task automatic redirect_compare();
        redirect_t e;
        assert (exp_redirect.size() > 0)
        else fail_run("Redirect pulse with no control instruction pending");
        e = exp_redirect.pop_front();
        expect_equal("redirect.target", redirect.target, e.target);
        expect_equal("redirect.taken", xword_t'(redirect.taken), xword_t'(e.taken));
        expect_equal("redirect.link", redirect.link, e.link);
    endtask

    // runs 1 ns before the rising edge and sees what that edge transfers
    task automatic sample_cycle();
        int  d;
        logic bub;
        cycle++;
        if (held) begin
            assert (retire_valid && retire.pc === held_pc)
            else fail_run("Retire bundle dropped or changed while retire_ready was low");
        end
        held    = retire_valid && !retire_ready;
        held_pc = retire.pc;
        if (retire_valid && retire_ready) begin
            retire_compare();
        end
        if (redirect_valid) begin
            redirect_compare();
        end
        if (in_valid && in_allowin) begin
            acc_cycle[drv_idx] = cycle;
            d = dep_dist[drv_idx];
            if (d > 0) begin
                bub = (cycle - acc_cycle[drv_idx - d]) > d;
                cov_hits[2'(d)][bub]++;
            end
            drv_idx++;
            took = 1'b1;
        end
    endtask

    initial begin
        dec_bundle_t d;
        xword_t      op_a;
        xword_t      op_b;
        rst            = 1'b1;
        in_valid       = 1'b1;  // a jump offered during reset
        in_bus         = '0;
        in_bus.br_kind = br_jal;
        retire_ready   = 1'b1;
        seed           = 32'h5656_e66a;
        golden[0]      = 64'd0;
        for (int r = 1; r < 32; r++) begin
            golden[r] = {$random(seed), $random(seed)};
        end
        shadow = golden;
        cov_hits = '{default: 0};
        for (int i = 0; i < n_instr; i++) begin
            d = make_instr(64'h1000 + 64'(4 * i));
            prog[i] = d;
            dep_dist[i] = 0;
            for (int j = i - 1; j >= 0 && j >= i - 3 && dep_dist[i] == 0; j--) begin
                if (prog[j].reg_wen && prog[j].rd != 5'd0 &&
                    ((prog[j].rd == d.rs1 && (d.a_sel == a_sel_reg || d.br_kind == br_jalr)) ||
                     (prog[j].rd == d.rs2 && (d.b_sel == b_sel_reg || d.mem_wen ||
                                              d.br_kind == br_branch)))) begin
                    dep_dist[i] = i - j;
                end
            end
            op_a = (d.a_sel == a_sel_reg) ? golden[d.rs1] :
                   (d.a_sel == a_sel_pc) ? d.pc : 64'd0;
            op_b = (d.b_sel == b_sel_reg) ? golden[d.rs2] :
                   (d.b_sel == b_sel_imm) ? d.imm :
                   (d.b_sel == b_sel_four) ? 64'd4 : 64'd0;
            exp_result[i] = alu_model(op_a, op_b, d.alu_op);
            exp_store[i]  = golden[d.rs2];
            if (d.br_kind != br_none) begin
                exp_redirect.push_back(redirect_model(d, golden[d.rs1], golden[d.rs2]));
            end
            if (d.reg_wen && d.rd != 5'd0) begin
                golden[d.rd] = exp_result[i];
            end
        end
        drv_idx = 0;
        ret_cnt = 0;
        cycle   = 0;
        took    = 1'b0;
        held    = 1'b0;
        repeat (rst_cycles) @(posedge clk);
        @(negedge clk);
        rst      = 1'b0;
        in_valid = 1'b0;
        #1;
        assert (!retire_valid && !redirect_valid && in_allowin)
        else fail_run("Outputs are not idle after reset");
        while (ret_cnt < n_instr) begin
            @(negedge clk);
            if (took) begin
                in_valid = 1'b0;
            end
            took = 1'b0;
            retire_ready = rand_below(4) != 0;
            if (!in_valid && drv_idx < n_instr) begin
                in_valid = rand_below(3) != 0;  // random input bubbles
            end
            if (in_valid) begin
                in_bus      = prog[drv_idx];
                in_bus.src1 = read_src(prog[drv_idx].rs1);
                in_bus.src2 = read_src(prog[drv_idx].rs2);
            end
            #1;
            sample_cycle();
        end
        for (int k = 1; k < 4; k++) begin
            for (int b = 0; b < 2; b++) begin
                assert (cov_hits[k][b] > 0)
                else fail_run($sformatf("Dependency at distance %0d never seen %s bubbles",
                                        k, (b == 1) ? "with" : "without"));
            end
        end
        if (exp_redirect.size() == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            fail_run("Control instructions left without a redirect pulse");
        end
    end

endmodule

`default_nettype wire

// File: exec_cluster.f
+incdir+include
hdl/rv_isa_pkg.sv
hdl/pipe_bus_pkg.sv
hdl/alu.sv
hdl/branch_unit.sv
hdl/forward_unit.sv
hdl/exe_stage.sv
hdl/retire_pipe.sv
hdl/exec_cluster.sv
testbench/exec_cluster_tb.sv

// File: Makefile
TOP       ?= exec_cluster_tb
FILELIST  ?= exec_cluster.f
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir
